//--- pe_tile_patterns.txt
# Kinds: T test number | C addr data (config write) | J block code (random junk to tile 0)
# V in_side0 in_side1 in_side2 in_side3 then expected out_side1 out_side2 out_side3, hex
T 1
V E F F F 0 0 0
V 5 A 3 C 0 0 0
V 0 F F F 0 0 0
T 2
C 00070003 FFAA5500
V 1 2 4 8 1 2 4
V A 5 C 3 A 5 C
V F 0 9 6 F 0 9
C 00070003 55FFFF00
V 1 2 4 8 8 8 1
V 6 3 9 C C C 6
C 00070003 934E3900
V 5 3 A C F 5 6
V A C 5 3 0 A 9
T 3
C 00070003 00000000
C 00060003 00000002
C 00050003 00000001
C 00040003 00000000
V 4 2 0 0 F F F
V 4 0 F F 0 0 0
C 00040003 00000001
V 3 D 0 0 0 0 0
V 0 2 0 0 F F F
C 00040003 00000002
V 4 2 0 0 0 0 0
V F D 0 0 F F F
C 00040003 00000003
V 4 2 0 0 0 0 0
V B 2 0 0 F F F
T 4
J 7
J 6
J 5
J 4
C 00000003 FFFFFFFF
C 00070002 FFAA5500
C 00040005 00000000
V 4 2 0 0 0 0 0
V 0 0 F F F F F
T 5
C 00070003 0000200C
C 00060003 00000005
C 00050003 00000006
C 00040003 00000002
V 0 0 4 2 4 0 0
V 0 0 0 2 B F F
V F F 4 0 F F F
V F F 0 D 0 0 0
C 00040003 00000003
V 0 0 4 2 4 0 0
V 0 0 4 0 F F F

//--- project.f
cgra_pkg.sv
tile_config.sv
connect_box.sv
clb.sv
switch_box_right.sv
pe_tile_right.sv
tb_pe_tile_right.sv

//--- Makefile
# Verilator flow for the right-edge tile.

TOP_TB  = tb_pe_tile_right
TOP_RTL = pe_tile_right

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP_RTL)

# The log search decides pass or fail.
sim:
	verilator --binary --timing -f project.f --top-module $(TOP_TB) -o sim_$(TOP_TB)
	./obj_dir/sim_$(TOP_TB) | tee sim.log
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_pe_tile_right.sv
`timescale 1ns/1ns

module tb_pe_tile_right;

	import cgra_pkg::*;

	localparam int          CLK_PERIOD      = 100;
	localparam int          SAMPLE_DELAY    = 40; // Just before the falling edge.
	localparam int          RESET_CYCLES    = 8;
	localparam int          CYCLES_PER_LINE = 20;
	localparam logic [15:0] OWN_TILE        = 16'd3;
	localparam logic [15:0] JUNK_TILE       = 16'd0;
	localparam logic [31:0] IDLE_ADDR       = 32'h0000_0000;
	localparam string       PATTERN_FILE    = "pe_tile_patterns.txt";

	logic                     clk;
	logic                     rst_n;
	cfg_addr_t                config_addr;
	cfg_word_u                config_data;
	logic [TILE_ID_WIDTH-1:0] tile_id;
	track_t                   in_side0;
	track_t                   in_side1;
	track_t                   in_side2;
	track_t                   in_side3;
	track_t                   out_side1;
	track_t                   out_side2;
	track_t                   out_side3;

	integer           seed;
	integer           fd;
	integer           code;
	integer           line_count;
	integer           cycle_count = 0;
	integer           cycle_limit = 1000;
	integer           error_count;
	integer           check_count;
	integer           test_id;
	integer           test_errors_at_start;
	integer           tests_run;
	integer           tests_failed;
	integer           pat_test;
	logic [7:0]       kind;
	logic [8*256-1:0] rest_of_line;
	logic [31:0]      pat_addr;
	logic [31:0]      pat_data;
	logic [15:0]      pat_blk;
	track_t           v0, v1, v2, v3;
	track_t           e1, e2, e3;

	pe_tile_right u_pe_tile_right (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_addr (config_addr),
		.config_data (config_data),
		.tile_id     (tile_id),
		.in_side0    (in_side0),
		.in_side1    (in_side1),
		.in_side2    (in_side2),
		.in_side3    (in_side3),
		.out_side1   (out_side1),
		.out_side2   (out_side2),
		.out_side3   (out_side3)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("The run timed out after %0d cycles before the patterns were done.",
				cycle_count);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ========================================
	// Checks and stimulus
	// ========================================
	task automatic check_side(input string name, input track_t got, input track_t expected);
		check_count = check_count + 1;
		if (got !== expected) begin
			error_count = error_count + 1;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	function automatic string test_title(input integer n);
		case (n)
			1: return "reset state";
			2: return "switch box routing";
			3: return "logic operations";
			4: return "address filtering";
			5: return "connect box selects 4 to 7";
			default: return "unnamed";
		endcase
	endfunction

	task automatic report_bad_line(input logic [7:0] line_kind);
		error_count = error_count + 1;
		$display("A pattern line of kind %s is malformed or unknown.", line_kind);
	endtask

	task automatic close_test();
		if (test_id > 0) begin
			tests_run = tests_run + 1;
			if (error_count == test_errors_at_start) begin
				$display("Test %0d, %s: passed", test_id, test_title(test_id));
			end else begin
				tests_failed = tests_failed + 1;
				$display("Test %0d, %s: failed with %0d errors", test_id,
					test_title(test_id), error_count - test_errors_at_start);
			end
		end
	endtask

	task automatic write_config(input logic [31:0] addr, input logic [31:0] data);
		@(negedge clk);
		config_addr = addr;
		config_data = data;
		@(posedge clk); // Stored at this edge.
	endtask

	task automatic apply_vector();
		@(negedge clk);
		config_addr = IDLE_ADDR;
		in_side0    = v0;
		in_side1    = v1;
		in_side2    = v2;
		in_side3    = v3;
		@(posedge clk); // Result register takes the operands here.
		#(SAMPLE_DELAY);
		check_side("out_side1", out_side1, e1);
		check_side("out_side2", out_side2, e2);
		check_side("out_side3", out_side3, e3);
	endtask

	task automatic read_patterns();
		logic done;
		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, "%s", kind);
			if (code != 1) begin
				done = 1'b1;
			end else if (kind == "#") begin
				code = $fgets(rest_of_line, fd);
			end else if (kind == "T") begin
				code = $fscanf(fd, "%d", pat_test);
				close_test();
				test_id              = pat_test;
				test_errors_at_start = error_count;
			end else if (kind == "C") begin
				code = $fscanf(fd, "%h %h", pat_addr, pat_data);
				if (code == 2) write_config(pat_addr, pat_data);
				else report_bad_line(kind);
			end else if (kind == "J") begin
				code     = $fscanf(fd, "%h", pat_blk);
				pat_data = $random(seed); // Junk for another tile.
				if (code == 1) write_config({pat_blk, JUNK_TILE}, pat_data);
				else report_bad_line(kind);
			end else if (kind == "V") begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h", v0, v1, v2, v3, e1, e2, e3);
				if (code == 7) apply_vector();
				else report_bad_line(kind);
			end else begin
				report_bad_line(kind);
				code = $fgets(rest_of_line, fd);
			end
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		seed                 = 32'h7ac6e22b;
		rst_n                = 1'b0;
		config_addr          = IDLE_ADDR;
		config_data          = '0;
		tile_id              = OWN_TILE;
		in_side0             = '0;
		in_side1             = '0;
		in_side2             = '0;
		in_side3             = '0;
		line_count           = 0;
		error_count          = 0;
		check_count          = 0;
		test_id              = 0;
		test_errors_at_start = 0;
		tests_run            = 0;
		tests_failed         = 0;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the pattern file %s.", PATTERN_FILE);
			$display("Result: FAILED");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(rest_of_line, fd);
				if (code > 0) line_count = line_count + 1;
			end
			$fclose(fd);
			cycle_limit = CYCLES_PER_LINE * line_count + RESET_CYCLES;
			fd = $fopen(PATTERN_FILE, "r");
			repeat (RESET_CYCLES) @(posedge clk);
			@(negedge clk);
			rst_n = 1'b1;
			read_patterns();
			close_test();
			$fclose(fd);
			$display("Tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
				tests_run, tests_failed, check_count, error_count);
			if (error_count == 0 && check_count > 0) begin
				$display("Result: PASSED");
			end else begin
				if (check_count == 0) $display("No output vectors were checked.");
				$display("Result: FAILED");
			end
			$finish;
		end
	end

endmodule

//--- pe_tile_right.sv
`timescale 1ns/1ns

module pe_tile_right (
	input  logic                               clk,
	input  logic                               rst_n,
	input  cgra_pkg::cfg_addr_t                config_addr,
	input  cgra_pkg::cfg_word_u                config_data,
	input  logic [cgra_pkg::TILE_ID_WIDTH-1:0] tile_id,
	input  cgra_pkg::track_t                   in_side0,
	input  cgra_pkg::track_t                   in_side1,
	input  cgra_pkg::track_t                   in_side2,
	input  cgra_pkg::track_t                   in_side3,
	output cgra_pkg::track_t                   out_side1,
	output cgra_pkg::track_t                   out_side2,
	output cgra_pkg::track_t                   out_side3
);

	import cgra_pkg::*;

	logic   cfg_en_sb;
	logic   cfg_en_cb0;
	logic   cfg_en_cb1;
	logic   cfg_en_clb;
	logic   op0;
	logic   op1;
	logic   pe_out;
	track_t sb_out_side0; // Side 0 faces off the array.

	// ========================================
	// Configuration decode
	// ========================================
	tile_config u_tile_config (
		.config_addr (config_addr),
		.tile_id     (tile_id),
		.cfg_en_sb   (cfg_en_sb),
		.cfg_en_cb0  (cfg_en_cb0),
		.cfg_en_cb1  (cfg_en_cb1),
		.cfg_en_clb  (cfg_en_clb)
	);

	// ========================================
	// Connect boxes
	// ========================================
	connect_box cb0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.tracks      ({sb_out_side0, in_side0}),
		.cfg_en      (cfg_en_cb0),
		.config_data (config_data),
		.block_out   (op0)
	);

	connect_box cb1 (
		.clk         (clk),
		.rst_n       (rst_n),
		.tracks      ({out_side1, in_side1}),
		.cfg_en      (cfg_en_cb1),
		.config_data (config_data),
		.block_out   (op1)
	);

	// ========================================
	// Logic block
	// ========================================
	clb compute_block (
		.clk         (clk),
		.rst_n       (rst_n),
		.in0         (op0),
		.in1         (op1),
		.cfg_en      (cfg_en_clb),
		.config_data (config_data),
		.out         (pe_out)
	);

	// ========================================
	// Switch box
	// ========================================
	switch_box_right sb (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_side0    (in_side0),
		.in_side1    (in_side1),
		.in_side2    (in_side2),
		.in_side3    (in_side3),
		.pe_in       (pe_out),
		.cfg_en      (cfg_en_sb),
		.config_data (config_data),
		.out_side0   (sb_out_side0), // Only feeds cb0.
		.out_side1   (out_side1),
		.out_side2   (out_side2),
		.out_side3   (out_side3)
	);

endmodule

//--- switch_box_right.sv
`timescale 1ns/1ns

module switch_box_right (
	input  logic                clk,
	input  logic                rst_n,
	input  cgra_pkg::track_t    in_side0,
	input  cgra_pkg::track_t    in_side1,
	input  cgra_pkg::track_t    in_side2,
	input  cgra_pkg::track_t    in_side3,
	input  logic                pe_in,
	input  logic                cfg_en,
	input  cgra_pkg::cfg_word_u config_data,
	output cgra_pkg::track_t    out_side0,
	output cgra_pkg::track_t    out_side1,
	output cgra_pkg::track_t    out_side2,
	output cgra_pkg::track_t    out_side3
);

	import cgra_pkg::*;

	// ========================================
	// Route register
	// ========================================
	sb_word_t route_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			route_q <= '0; // Every output takes the logic block result.
		end else if (cfg_en) begin
			route_q <= config_data.sb;
		end
	end

	// ========================================
	// Side arrays
	// ========================================
	wire [NUM_SIDES-1:0][NUM_TRACKS-1:0] side_in;
	wire [NUM_SIDES-1:0][NUM_TRACKS-1:0] side_out;

	assign side_in = {in_side3, in_side2, in_side1, in_side0};

	// ========================================
	// Output multiplexers
	// ========================================
	for (genvar s = 0; s < NUM_SIDES; s++) begin : g_side
		// The three other sides in rising order, own side skipped.
		localparam int SIDE_A = (s == 0) ? 1 : 0;
		localparam int SIDE_B = (s <= 1) ? 2 : 1;
		localparam int SIDE_C = (s <= 2) ? 3 : 2;

		for (genvar t = 0; t < NUM_TRACKS; t++) begin : g_track
			wire [3:0] cand;

			// Index 0 matches SB_SEL_PE.
			assign cand = {
				side_in[SIDE_C][t],
				side_in[SIDE_B][t],
				side_in[SIDE_A][t],
				pe_in
			};
			assign side_out[s][t] = cand[route_q[NUM_TRACKS*s+t]];
		end
	end

	assign out_side0 = side_out[0];
	assign out_side1 = side_out[1];
	assign out_side2 = side_out[2];
	assign out_side3 = side_out[3];

endmodule

//--- clb.sv
`timescale 1ns/1ns

module clb (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in0,
	input  logic                in1,
	input  logic                cfg_en,
	input  cgra_pkg::cfg_word_u config_data,
	output logic                out
);

	import cgra_pkg::*;

	clb_op_e op_q;
	logic    result;

	// ========================================
	// Operation decode
	// ========================================
	always_comb begin
		case (op_q)
			OP_AND:  result = in0 & in1;
			OP_OR:   result = in0 | in1;
			OP_XOR:  result = in0 ^ in1;
			OP_NAND: result = ~(in0 & in1);
			default: result = 1'b0;
		endcase
	end

	// ========================================
	// Configuration and result registers
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_q <= OP_AND;
			out  <= 1'b0;
		end else begin
			if (cfg_en) begin
				op_q <= config_data.clb.op;
			end
			out <= result; // Also breaks the route feedback loop.
		end
	end

endmodule

//--- connect_box.sv
`timescale 1ns/1ns

module connect_box (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [7:0]          tracks,
	input  logic                cfg_en,
	input  cgra_pkg::cfg_word_u config_data,
	output logic                block_out
);

	import cgra_pkg::*;

	// ========================================
	// Track select register
	// ========================================
	logic [CB_SEL_WIDTH-1:0] sel_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= '0; // Track 0 after reset.
		end else if (cfg_en) begin
			sel_q <= config_data.cb.sel;
		end
	end

	// ========================================
	// Operand multiplexer
	// ========================================
	// Tracks 0..3 come from the side inputs.
	// Tracks 4..7 come from the switch box outputs of the same side.
	assign block_out = tracks[sel_q];

endmodule

//--- tile_config.sv
`timescale 1ns/1ns

module tile_config (
	input  cgra_pkg::cfg_addr_t                 config_addr,
	input  logic [cgra_pkg::TILE_ID_WIDTH-1:0]  tile_id,
	output logic                                cfg_en_sb,
	output logic                                cfg_en_cb0,
	output logic                                cfg_en_cb1,
	output logic                                cfg_en_clb
);

	import cgra_pkg::*;

	logic tile_hit;

	// Tile match is shared by all four block decodes.
	assign tile_hit = (config_addr.tile == tile_id);

	always_comb begin
		cfg_en_sb  = 1'b0;
		cfg_en_cb0 = 1'b0;
		cfg_en_cb1 = 1'b0;
		cfg_en_clb = 1'b0;
		if (tile_hit) begin
			case (config_addr.blk)
				BLK_SB: begin
					cfg_en_sb = 1'b1;
				end
				BLK_CB0: begin
					cfg_en_cb0 = 1'b1;
				end
				BLK_CB1: begin
					cfg_en_cb1 = 1'b1;
				end
				BLK_CLB: begin
					cfg_en_clb = 1'b1;
				end
				default: begin
					cfg_en_sb  = 1'b0; // Unknown code or code 0.
					cfg_en_cb0 = 1'b0;
					cfg_en_cb1 = 1'b0;
					cfg_en_clb = 1'b0;
				end
			endcase
		end
	end

endmodule

//--- cgra_pkg.sv
package cgra_pkg;

	// ========================================
	// Track and configuration word sizes
	// ========================================
	localparam int NUM_TRACKS    = 4;
	localparam int NUM_SIDES     = 4;
	localparam int CFG_WIDTH     = 32;
	localparam int TILE_ID_WIDTH = 16;
	localparam int CB_SEL_WIDTH  = 3;
	localparam int SB_SEL_WIDTH  = 2;

	typedef logic [NUM_TRACKS-1:0] track_t; // Bit t is track t.

	// ========================================
	// Configuration address
	// ========================================
	localparam logic [15:0] BLK_SB  = 16'd7;
	localparam logic [15:0] BLK_CB0 = 16'd6;
	localparam logic [15:0] BLK_CB1 = 16'd5;
	localparam logic [15:0] BLK_CLB = 16'd4;

	typedef struct packed {
		logic [CFG_WIDTH-TILE_ID_WIDTH-1:0] blk; // Block code.
		logic [TILE_ID_WIDTH-1:0]           tile; // Target tile id.
	} cfg_addr_t;

	// ========================================
	// Block encodings
	// ========================================
	typedef enum logic [1:0] {
		OP_AND  = 2'd0,
		OP_OR   = 2'd1,
		OP_XOR  = 2'd2,
		OP_NAND = 2'd3
	} clb_op_e;

	// Selects 1..3 pick the other sides in rising order.
	localparam logic [SB_SEL_WIDTH-1:0] SB_SEL_PE = 2'd0;

	// ========================================
	// Configuration data views
	// ========================================
	typedef struct packed {
		logic [CFG_WIDTH-CB_SEL_WIDTH-1:0] pad;
		logic [CB_SEL_WIDTH-1:0]           sel; // Track select.
	} cb_word_t;

	typedef struct packed {
		logic [CFG_WIDTH-3:0] pad;
		clb_op_e              op;
	} clb_word_t;

	// Select for side s, track t sits at index NUM_TRACKS*s+t.
	typedef logic [NUM_SIDES*NUM_TRACKS-1:0][SB_SEL_WIDTH-1:0] sb_word_t;

	typedef union packed {
		cb_word_t  cb;
		clb_word_t clb;
		sb_word_t  sb;
	} cfg_word_u;

endpackage
